//--- design/deflate_fmt_pkg.sv
package deflate_fmt_pkg;

   ////////////////////////////////////////
   // Field types
   ////////////////////////////////////////
   typedef logic [63:0] word_t;   // One stream word
   typedef logic [7:0]  byte_t;   // CMF or FLG
   typedef logic [15:0] len_t;    // Stored LEN or NLEN
   typedef logic [5:0]  align_t;  // Bit alignment of a raw frame
   typedef logic [1:0]  btype_t;  // Deflate block type

   // zlib constants
   localparam logic [3:0] zlib_cm_deflate = 4'd8;
   localparam int         zlib_fcheck_mod = 31;

   ////////////////////////////////////////
   // Bit positions in the sof word
   ////////////////////////////////////////
   localparam int zlib_cmf_lsb    = 0;
   localparam int zlib_flg_lsb    = 8;
   localparam int zlib_fdict_bit  = 13;
   localparam int zlib_bfinal_bit = 16;
   localparam int zlib_btype_lsb  = 17;
   localparam int zlib_len_lsb    = 24;
   localparam int zlib_nlen_lsb   = 40;

   localparam int raw_bfinal_bit  = 0;
   localparam int raw_btype_lsb   = 1;

   // Block types
   localparam btype_t btype_stored   = 2'd0;
   localparam btype_t btype_fixed    = 2'd1;
   localparam btype_t btype_dynamic  = 2'd2;
   localparam btype_t btype_reserved = 2'd3;

   // Header sizes in bits
   localparam int zlib_hdr_bits    = 19;
   localparam int zlib_stored_bits = 56;
   localparam int raw_hdr_bits     = 3;
   localparam int raw_stored_bits  = 35;  // Padding comes on top

endpackage

//--- design/bhp_status_pkg.sv
package bhp_status_pkg;

   ////////////////////////////////////////
   // Status record fields
   ////////////////////////////////////////

   // Header bits consumed within the first word
   typedef logic [6:0] bit_cnt_t;

   localparam bit_cnt_t bit_cnt_max = 7'd64;  // One full word

   // Reported block format
   typedef enum logic [1:0] {
      fmt_raw     = 2'd0,
      fmt_fixed   = 2'd1,
      fmt_dynamic = 2'd2
   } blk_fmt_e;

   // Error codes, one per record
   typedef enum logic [2:0] {
      err_none           = 3'd0,
      err_cm_not_deflate = 3'd1,
      err_cinfo_range    = 3'd2,
      err_fcheck         = 3'd3,
      err_hdr_invalid    = 3'd4,
      err_fdict_prsnt    = 3'd5,
      err_len_check      = 3'd6
   } bhp_err_e;

endpackage

//--- design/bhp_decode.sv
`timescale 1ns/1ps

module bhp_decode (
   input  logic                    clk,
   input  logic                    rst_n,
   input  deflate_fmt_pkg::word_t  in_data,
   input  logic                    in_sof,
   input  logic                    in_valid,
   input  logic                    frm_zlib,
   input  deflate_fmt_pkg::align_t align_bits,
   input  logic                    x_ready,
   output logic                    in_ready,
   output logic                    d_valid,
   output logic                    d_zlib,
   output deflate_fmt_pkg::byte_t  d_cmf,
   output deflate_fmt_pkg::byte_t  d_flg,
   output logic                    d_bfinal,
   output deflate_fmt_pkg::btype_t d_btype,
   output deflate_fmt_pkg::len_t   d_len,
   output deflate_fmt_pkg::len_t   d_nlen,
   output logic [2:0]              d_pad
);

   import deflate_fmt_pkg::*;

   logic       rdy_en;     // Set once out of reset
   logic       sof_take;
   logic [2:0] pad;
   logic [3:0] raw_shamt;
   word_t      raw_word;

   byte_t      cmf_nxt;
   byte_t      flg_nxt;
   logic       bfinal_nxt;
   btype_t     btype_nxt;
   len_t       len_nxt;
   len_t       nlen_nxt;
   logic [2:0] pad_nxt;

   // Register loads when empty or drained this cycle
   assign in_ready = rdy_en && (!d_valid || x_ready);
   assign sof_take = in_ready && in_valid && in_sof;

   ////////////////////////////////////////
   // Field extraction
   ////////////////////////////////////////
   always_comb begin
      // Pad the stored header up to the next byte boundary
      pad       = 3'd0 - (align_bits[2:0] + 3'd3);
      raw_shamt = 4'(raw_hdr_bits) + {1'b0, pad};
      raw_word  = in_data >> raw_shamt;

      if (frm_zlib) begin
         cmf_nxt    = in_data[zlib_cmf_lsb +: 8];
         flg_nxt    = in_data[zlib_flg_lsb +: 8];
         bfinal_nxt = in_data[zlib_bfinal_bit];
         btype_nxt  = in_data[zlib_btype_lsb +: 2];
         len_nxt    = in_data[zlib_len_lsb +: 16];
         nlen_nxt   = in_data[zlib_nlen_lsb +: 16];
         pad_nxt    = 3'd0;  // zlib header ends byte aligned
      end else begin
         cmf_nxt    = '0;
         flg_nxt    = '0;
         bfinal_nxt = in_data[raw_bfinal_bit];
         btype_nxt  = in_data[raw_btype_lsb +: 2];
         len_nxt    = raw_word[15:0];
         nlen_nxt   = raw_word[31:16];
         pad_nxt    = pad;
      end
   end

   ////////////////////////////////////////
   // Pipeline register
   ////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rdy_en  <= 1'b0;
         d_valid <= 1'b0;
      end else begin
         rdy_en <= 1'b1;
         if (in_ready) begin
            d_valid <= in_valid && in_sof;  // Non-sof words drop here
         end
      end
   end

   always_ff @(posedge clk) begin
      if (sof_take) begin
         d_zlib   <= frm_zlib;
         d_cmf    <= cmf_nxt;
         d_flg    <= flg_nxt;
         d_bfinal <= bfinal_nxt;
         d_btype  <= btype_nxt;
         d_len    <= len_nxt;
         d_nlen   <= nlen_nxt;
         d_pad    <= pad_nxt;
      end
   end

   // Held frame must not change under back-pressure from execute/result
   a_hold_stable: assert property (
      @(posedge clk) disable iff (!rst_n)
      d_valid && !x_ready |=> d_valid &&
         $stable({d_zlib, d_cmf, d_flg, d_bfinal, d_btype, d_len, d_nlen, d_pad})
   ) else $error("decode register changed while held");

endmodule

//--- design/bhp_execute.sv
`timescale 1ns/1ps

module bhp_execute #(
   parameter logic [3:0] cinfo_expected = 4'd7
) (
   input  logic                      d_valid,
   input  logic                      d_zlib,
   input  deflate_fmt_pkg::byte_t    d_cmf,
   input  deflate_fmt_pkg::byte_t    d_flg,
   input  logic                      d_bfinal,
   input  deflate_fmt_pkg::btype_t   d_btype,
   input  deflate_fmt_pkg::len_t     d_len,
   input  deflate_fmt_pkg::len_t     d_nlen,
   input  logic [2:0]                d_pad,
   input  logic                      result_ready,
   output logic                      x_ready,
   output logic                      x_valid,
   output bhp_status_pkg::blk_fmt_e  x_fmt,
   output bhp_status_pkg::bhp_err_e  x_err,
   output bhp_status_pkg::bit_cnt_t  x_bits,
   output logic                      x_blast,
   output deflate_fmt_pkg::len_t     x_len
);

   import deflate_fmt_pkg::*;
   import bhp_status_pkg::*;

   logic     stored;
   logic     cm_err;
   logic     cinfo_err;
   logic     fcheck_err;
   logic     hdr_err;
   logic     fdict_err;
   logic     len_err;
   blk_fmt_e btype_fmt;

   assign x_ready = result_ready;
   assign x_valid = d_valid;
   assign x_blast = d_bfinal;

   ////////////////////////////////////////
   // Individual checks
   ////////////////////////////////////////
   assign stored     = (d_btype == btype_stored);
   assign cm_err     = (d_cmf[3:0] != zlib_cm_deflate);
   assign cinfo_err  = (d_cmf[7:4] != cinfo_expected);
   assign fcheck_err = (({d_cmf, d_flg} % 16'(zlib_fcheck_mod)) != 16'd0);
   assign hdr_err    = (d_btype == btype_reserved);
   assign fdict_err  = d_flg[zlib_fdict_bit - zlib_flg_lsb];
   assign len_err    = stored && (d_nlen != ~d_len);

   // Stored and reserved block types both map to raw
   always_comb begin
      case (d_btype)
         btype_fixed:   btype_fmt = fmt_fixed;
         btype_dynamic: btype_fmt = fmt_dynamic;
         default:       btype_fmt = fmt_raw;
      endcase
   end

   ////////////////////////////////////////
   // Error priority and results
   ////////////////////////////////////////
   always_comb begin
      x_err = err_none;
      if (d_zlib) begin
         if (cm_err)          x_err = err_cm_not_deflate;
         else if (cinfo_err)  x_err = err_cinfo_range;
         else if (fcheck_err) x_err = err_fcheck;
         else if (hdr_err)    x_err = err_hdr_invalid;
         else if (fdict_err)  x_err = err_fdict_prsnt;
         else if (len_err)    x_err = err_len_check;
      end else begin
         if (hdr_err)         x_err = err_hdr_invalid;
         else if (len_err)    x_err = err_len_check;
      end

      // Any error reports a raw format
      x_fmt = (x_err == err_none) ? btype_fmt : fmt_raw;

      if (d_zlib) begin
         x_bits = stored ? bit_cnt_t'(zlib_stored_bits) : bit_cnt_t'(zlib_hdr_bits);
      end else if (stored) begin
         x_bits = bit_cnt_t'(raw_stored_bits) + {4'd0, d_pad};
      end else begin
         x_bits = bit_cnt_t'(raw_hdr_bits);
      end

      x_len = stored ? d_len : '0;
   end

   // Header must fit inside the first word
   always_comb begin
      if (x_valid) begin
         a_bits_fit: assert (x_bits <= bit_cnt_max)
            else $error("bits consumed %0d exceeds one word", x_bits);
      end
   end

endmodule

//--- design/bhp_result.sv
`timescale 1ns/1ps

module bhp_result (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     x_valid,
   input  bhp_status_pkg::blk_fmt_e x_fmt,
   input  bhp_status_pkg::bhp_err_e x_err,
   input  bhp_status_pkg::bit_cnt_t x_bits,
   input  logic                     x_blast,
   input  deflate_fmt_pkg::len_t    x_len,
   input  logic                     status_ready,
   output logic                     result_ready,
   output logic                     status_valid,
   output bhp_status_pkg::blk_fmt_e status_fmt,
   output bhp_status_pkg::bhp_err_e status_err,
   output bhp_status_pkg::bit_cnt_t status_bits,
   output logic                     status_blast,
   output deflate_fmt_pkg::len_t    status_len
);

   // Free when empty or the record leaves this cycle
   assign result_ready = !status_valid || status_ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         status_valid <= 1'b0;
      end else if (result_ready) begin
         status_valid <= x_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (result_ready && x_valid) begin
         status_fmt   <= x_fmt;
         status_err   <= x_err;
         status_bits  <= x_bits;
         status_blast <= x_blast;
         status_len   <= x_len;
      end
   end

   ////////////////////////////////////////
   // Output hold check
   ////////////////////////////////////////
   a_status_stable: assert property (
      @(posedge clk) disable iff (!rst_n)
      status_valid && !status_ready |=> status_valid &&
         $stable({status_fmt, status_err, status_bits, status_blast, status_len})
   ) else $error("status record changed while held");

endmodule

//--- design/deflate_bhp.sv
`timescale 1ns/1ps

module deflate_bhp #(
   parameter logic [3:0] cinfo_expected = 4'd7  // Accepted zlib window code
) (
   input  logic                     clk,
   input  logic                     rst_n,
   input  deflate_fmt_pkg::word_t   in_data,
   input  logic                     in_sof,
   input  logic                     in_valid,
   output logic                     in_ready,
   input  logic                     frm_zlib,
   input  deflate_fmt_pkg::align_t  align_bits,
   output logic                     status_valid,
   input  logic                     status_ready,
   output bhp_status_pkg::blk_fmt_e status_fmt,
   output bhp_status_pkg::bhp_err_e status_err,
   output bhp_status_pkg::bit_cnt_t status_bits,
   output logic                     status_blast,
   output deflate_fmt_pkg::len_t    status_len
);

   import deflate_fmt_pkg::*;
   import bhp_status_pkg::*;

   // Decode to execute
   logic       d_valid;
   logic       d_zlib;
   byte_t      d_cmf;
   byte_t      d_flg;
   logic       d_bfinal;
   btype_t     d_btype;
   len_t       d_len;
   len_t       d_nlen;
   logic [2:0] d_pad;

   // Execute to result
   logic       x_ready;
   logic       x_valid;
   blk_fmt_e   x_fmt;
   bhp_err_e   x_err;
   bit_cnt_t   x_bits;
   logic       x_blast;
   len_t       x_len;
   logic       result_ready;

   bhp_decode i_bhp_decode (
      .clk, .rst_n, .in_data, .in_sof, .in_valid, .frm_zlib, .align_bits,
      .x_ready, .in_ready, .d_valid, .d_zlib, .d_cmf, .d_flg, .d_bfinal,
      .d_btype, .d_len, .d_nlen, .d_pad
   );

   bhp_execute #(.cinfo_expected(cinfo_expected)) i_bhp_execute (
      .d_valid, .d_zlib, .d_cmf, .d_flg, .d_bfinal, .d_btype, .d_len, .d_nlen,
      .d_pad, .result_ready, .x_ready, .x_valid, .x_fmt, .x_err, .x_bits,
      .x_blast, .x_len
   );

   bhp_result i_bhp_result (
      .clk, .rst_n, .x_valid, .x_fmt, .x_err, .x_bits, .x_blast, .x_len,
      .status_ready, .result_ready, .status_valid, .status_fmt, .status_err,
      .status_bits, .status_blast, .status_len
   );

endmodule

//--- test/tb_deflate_bhp.sv
`timescale 1ns/1ps

module tb_deflate_bhp;

   import deflate_fmt_pkg::*;
   import bhp_status_pkg::*;

   localparam int          clk_period = 8;
   localparam logic [31:0] seed       = 32'he95c7862;
   localparam logic [3:0]  cinfo_exp  = 4'd5;

   // Frames per test
   localparam int n_valid  = 24;
   localparam int n_err    = 32;
   localparam int n_raw    = 24;
   localparam int n_stored = 24;
   localparam int n_bp     = 64;
   localparam int max_gap  = 3;  // Non-sof words after a frame
   localparam int n_words  = n_valid + n_err + 2 * n_raw + n_stored + n_bp * (1 + max_gap) + 1;
   localparam int watchdog_cycles = n_words * 20;

   logic        clk;
   logic        rst_n;
   word_t       in_data;
   logic        in_sof;
   logic        in_valid;
   logic        in_ready;
   logic        frm_zlib;
   align_t      align_bits;
   logic        status_valid;
   logic        status_ready = 1'b1;
   blk_fmt_e    status_fmt;
   bhp_err_e    status_err;
   bit_cnt_t    status_bits;
   logic        status_blast;
   len_t        status_len;

   // Expected records {fmt, err, bits, blast, len}
   logic [28:0] exp_mem [0:255];
   logic [7:0]  wr_ptr       = '0;
   logic [7:0]  rd_ptr       = '0;
   logic [28:0] exp_head;
   logic [28:0] status_rec;
   int          words_taken  = 0;
   int          records_seen = 0;
   int          frames_sent  = 0;
   int          errors       = 0;
   logic        bp_en        = 1'b0;
   logic        acc_sof_d1;
   logic        load_due;
   logic        held;
   logic [28:0] held_rec;

   deflate_bhp #(.cinfo_expected(cinfo_exp)) i_deflate_bhp (
      .clk, .rst_n, .in_data, .in_sof, .in_valid, .in_ready, .frm_zlib, .align_bits,
      .status_valid, .status_ready, .status_fmt, .status_err, .status_bits,
      .status_blast, .status_len
   );

   assign exp_head   = exp_mem[rd_ptr];
   assign status_rec = {status_fmt, status_err, status_bits, status_blast, status_len};

   ////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////
   function automatic logic [28:0] expect_record(input word_t w, input logic zl,
                                                 input align_t al);
      byte_t    cmf;
      byte_t    flg;
      logic     bfinal;
      btype_t   bt;
      len_t     len;
      len_t     nlen;
      logic     stored;
      int       pad;
      int       bits;
      bhp_err_e err;
      blk_fmt_e fmt;
      if (zl) begin
         cmf    = w[7:0];
         flg    = w[15:8];
         bfinal = w[16];
         bt     = w[18:17];
         len    = w[39:24];
         nlen   = w[55:40];
         pad    = 0;
      end else begin
         cmf    = '0;
         flg    = '0;
         pad    = (8 - ((int'(al) + 3) % 8)) % 8;  // Up to the next byte boundary
         bfinal = w[0];
         bt     = w[2:1];
         len    = w[(3 + pad) +: 16];
         nlen   = w[(19 + pad) +: 16];
      end
      stored = (bt == 2'd0);
      err    = err_none;
      if (zl && cmf[3:0] != 4'd8)                               err = err_cm_not_deflate;
      else if (zl && cmf[7:4] != cinfo_exp)                     err = err_cinfo_range;
      else if (zl && (int'(cmf) * 256 + int'(flg)) % 31 != 0)   err = err_fcheck;
      else if (bt == 2'd3)                                      err = err_hdr_invalid;
      else if (zl && flg[5])                                    err = err_fdict_prsnt;
      else if (stored && nlen != ~len)                          err = err_len_check;
      if (err != err_none)    fmt = fmt_raw;
      else if (bt == 2'd1)    fmt = fmt_fixed;
      else if (bt == 2'd2)    fmt = fmt_dynamic;
      else                    fmt = fmt_raw;
      bits = zl ? (stored ? 56 : 19) : (stored ? 35 + pad : 3);
      return {fmt, err, bit_cnt_t'(bits), bfinal, stored ? len : 16'd0};
   endfunction

   function automatic len_t pick_nlen(input len_t len, input logic bad);
      return bad ? (~len ^ (16'($urandom) | 16'd1)) : ~len;
   endfunction

   function automatic word_t make_zlib_word(input logic [3:0] cm, input logic [3:0] cinfo,
                                            input logic fdict, input logic bad_fck,
                                            input logic bfinal, input btype_t bt,
                                            input len_t len, input logic bad_nlen);
      word_t w;
      byte_t cmf;
      byte_t flg;
      int    rem;
      w   = {$urandom, $urandom};
      cmf = {cinfo, cm};
      flg = {2'($urandom), fdict, 5'd0};
      rem = (int'(cmf) * 256 + int'(flg)) % 31;
      flg[4:0] = 5'((31 - rem) % 31);
      if (bad_fck) flg[4:0] = flg[4:0] + 5'd1;  // Remainder becomes 1
      w[7:0]   = cmf;
      w[15:8]  = flg;
      w[16]    = bfinal;
      w[18:17] = bt;
      w[39:24] = len;
      w[55:40] = pick_nlen(len, bad_nlen);
      return w;
   endfunction

   function automatic word_t make_raw_word(input align_t al, input logic bfinal,
                                           input btype_t bt, input len_t len,
                                           input logic bad_nlen);
      word_t w;
      int    pad;
      w   = {$urandom, $urandom};
      pad = (8 - ((int'(al) + 3) % 8)) % 8;
      w[0]   = bfinal;
      w[2:1] = bt;
      w[(3 + pad) +: 16]  = len;
      w[(19 + pad) +: 16] = pick_nlen(len, bad_nlen);
      return w;
   endfunction

   function automatic void flag_value(input string name, input logic [15:0] exp_val,
                                      input logic [15:0] act_val);
      errors++;
      $display("[FAIL] time %0d ns: %s expected %0d, got %0d", $time, name, exp_val, act_val);
   endfunction

   function automatic void flag_event(input string what);
      errors++;
      $display("Error at time %0d ns: %s", $time, what);
   endfunction

   ////////////////////////////////////////
   // Clock, status_ready and scoreboard
   ////////////////////////////////////////
   initial begin : clock_gen
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   always @(negedge clk) begin
      status_ready <= bp_en ? ($urandom % 3 != 0) : 1'b1;
   end

   always @(posedge clk) begin
      if (rst_n && in_valid && in_ready) begin
         words_taken <= words_taken + 1;
         if (in_sof) begin
            exp_mem[wr_ptr] <= expect_record(in_data, frm_zlib, align_bits);
            wr_ptr          <= wr_ptr + 8'd1;
         end
      end
      if (rst_n && status_valid && status_ready) begin
         rd_ptr       <= rd_ptr + 8'd1;
         records_seen <= records_seen + 1;
      end
   end

   // History for the latency and hold checks
   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         acc_sof_d1 <= 1'b0;
         load_due   <= 1'b0;
         held       <= 1'b0;
         held_rec   <= '0;
      end else begin
         acc_sof_d1 <= in_valid && in_ready && in_sof;
         load_due   <= acc_sof_d1 && status_ready;
         held       <= status_valid && !status_ready;
         held_rec   <= status_rec;
      end
   end

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////
   a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !status_valid && !in_ready)
      else flag_event("status_valid or in_ready high during reset");

   a_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
      status_valid && status_ready |-> wr_ptr != rd_ptr)
      else flag_event("record delivered with no frame outstanding");

   a_fmt: assert property (@(posedge clk) disable iff (!rst_n)
      status_valid && status_ready |-> status_fmt == exp_head[28:27])
      else flag_value("status_fmt", 16'($sampled(exp_head[28:27])), 16'($sampled(status_fmt)));

   a_err: assert property (@(posedge clk) disable iff (!rst_n)
      status_valid && status_ready |-> status_err == exp_head[26:24])
      else flag_value("status_err", 16'($sampled(exp_head[26:24])), 16'($sampled(status_err)));

   a_bits: assert property (@(posedge clk) disable iff (!rst_n)
      status_valid && status_ready |-> status_bits == exp_head[23:17])
      else flag_value("status_bits", 16'($sampled(exp_head[23:17])),
                      16'($sampled(status_bits)));

   a_blast: assert property (@(posedge clk) disable iff (!rst_n)
      status_valid && status_ready |-> status_blast == exp_head[16])
      else flag_value("status_blast", 16'($sampled(exp_head[16])),
                      16'($sampled(status_blast)));

   a_len: assert property (@(posedge clk) disable iff (!rst_n)
      status_valid && status_ready |-> status_len == exp_head[15:0])
      else flag_value("status_len", $sampled(exp_head[15:0]), $sampled(status_len));

   a_hold: assert property (@(posedge clk) disable iff (!rst_n)
      held |-> status_valid && status_rec == held_rec)
      else flag_event("status record changed while status_ready was low");

   a_latency: assert property (@(posedge clk) disable iff (!rst_n) load_due |-> status_valid)
      else flag_event("status_valid missing two edges after sof acceptance");

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////
   task automatic send_word(input word_t w, input logic sof, input logic zl, input align_t al);
      int start;
      start      = words_taken;
      in_data    = w;
      in_sof     = sof;
      frm_zlib   = zl;
      align_bits = al;
      in_valid   = 1'b1;
      do begin
         @(negedge clk);
      end while (words_taken == start);
      in_valid = 1'b0;
      if (sof) frames_sent++;
   endtask

   task automatic send_noise();
      send_word({$urandom, $urandom}, 1'b0, 1'($urandom), 6'($urandom));
   endtask

   task automatic wait_drain();
      while (wr_ptr != rd_ptr) @(negedge clk);
      repeat (3) @(negedge clk);  // Catch stray records
   endtask

   task automatic run_zlib_valid();
      repeat (n_valid) begin
         send_word(make_zlib_word(4'd8, cinfo_exp, 1'b0, 1'b0, 1'($urandom),
                   btype_t'(1 + $urandom % 2), 16'($urandom), 1'b0), 1'b1, 1'b1, 6'($urandom));
      end
   endtask

   task automatic run_zlib_errors();
      logic [3:0] cm;
      logic [3:0] cinfo;
      logic       fdict;
      logic       bad_fck;
      int         kind;
      for (int i = 0; i < n_err; i++) begin
         kind    = i % 4;
         cm      = 4'd8;
         cinfo   = cinfo_exp;
         fdict   = 1'b0;
         bad_fck = 1'b0;
         // Lower priority faults ride along at random
         if (kind < 3) fdict = 1'($urandom);
         if (kind < 2) bad_fck = 1'($urandom);
         if (kind < 1) cinfo = 4'($urandom);
         if (kind == 0)      cm = 4'd8 ^ (4'($urandom) | 4'd1);
         else if (kind == 1) cinfo = cinfo_exp ^ (4'($urandom) | 4'd1);
         else if (kind == 2) bad_fck = 1'b1;
         else                fdict = 1'b1;
         send_word(make_zlib_word(cm, cinfo, fdict, bad_fck, 1'($urandom),
                   btype_t'(1 + $urandom % 2), 16'($urandom), 1'b0), 1'b1, 1'b1, 6'($urandom));
      end
   endtask

   task automatic run_raw_stored();
      align_t al;
      for (int i = 0; i < n_raw; i++) begin
         al = 6'($urandom);
         send_word(make_raw_word(al, 1'($urandom), 2'd0, 16'($urandom), i % 2 == 1),
                   1'b1, 1'b0, al);
         send_noise();
      end
   endtask

   task automatic run_stored_reserved();
      align_t al;
      int     kind;
      for (int i = 0; i < n_stored; i++) begin
         al   = 6'($urandom);
         kind = i % 4;
         if (kind < 3) begin  // zlib stored good, stored bad, then reserved type
            send_word(make_zlib_word(4'd8, cinfo_exp, 1'b0, 1'b0, 1'($urandom),
                      (kind == 2) ? 2'd3 : 2'd0, 16'($urandom), kind == 1), 1'b1, 1'b1, al);
         end else begin
            send_word(make_raw_word(al, 1'($urandom), 2'd3, 16'($urandom), 1'b0), 1'b1, 1'b0, al);
         end
      end
   endtask

   task automatic run_backpressure();
      align_t al;
      bp_en = 1'b1;
      for (int i = 0; i < n_bp; i++) begin
         al = 6'($urandom);
         if (1'($urandom)) begin
            send_word(make_zlib_word(4'd8, cinfo_exp, 1'b0, 1'b0, 1'($urandom), 2'($urandom),
                      16'($urandom), 1'($urandom)), 1'b1, 1'b1, al);
         end else begin
            send_word(make_raw_word(al, 1'($urandom), 2'($urandom), 16'($urandom),
                      1'($urandom)), 1'b1, 1'b0, al);
         end
         repeat ($urandom % (max_gap + 1)) send_noise();
      end
      wait_drain();
      bp_en = 1'b0;
   endtask

   task automatic run_reset_latency();
      wait_drain();
      rst_n = 1'b0;
      repeat (3) @(negedge clk);
      rst_n = 1'b1;
      send_word(make_zlib_word(4'd8, cinfo_exp, 1'b0, 1'b0, 1'b1, 2'd1, 16'($urandom), 1'b0),
                1'b1, 1'b1, 6'($urandom));
   endtask

   task automatic report_test(input string name, input int errs_before);
      wait_drain();
      $display("Test %-16s %s", name, (errors == errs_before) ? "passed" : "FAILED");
   endtask

   ////////////////////////////////////////
   // Main flow
   ////////////////////////////////////////
   initial begin : main_flow
      int e0;
      void'($urandom(seed));
      rst_n      = 1'b1;
      in_data    = '0;
      in_sof     = 1'b0;
      in_valid   = 1'b0;
      frm_zlib   = 1'b0;
      align_bits = '0;
      #1 rst_n = 1'b0;
      repeat (3) @(negedge clk);
      rst_n = 1'b1;

      e0 = errors;
      run_zlib_valid();
      report_test("zlib_valid", e0);
      e0 = errors;
      run_zlib_errors();
      report_test("zlib_errors", e0);
      e0 = errors;
      run_raw_stored();
      report_test("raw_stored", e0);
      e0 = errors;
      run_stored_reserved();
      report_test("stored_reserved", e0);
      e0 = errors;
      run_backpressure();
      report_test("backpressure", e0);
      e0 = errors;
      run_reset_latency();
      report_test("reset_latency", e0);

      a_all_records: assert (records_seen == frames_sent)
         else flag_event("record count does not match the frames sent");
      $display("Frames %0d, records %0d, errors %0d", frames_sent, records_seen, errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   initial begin : watchdog
      #(watchdog_cycles * clk_period);
      $display("Run timed out after %0d cycles before all tests finished", watchdog_cycles);
      $display("Simulation failed");
      $finish;
   end

endmodule

//--- deflate_bhp.f
design/deflate_fmt_pkg.sv
design/bhp_status_pkg.sv
design/bhp_decode.sv
design/bhp_execute.sv
design/bhp_result.sv
design/deflate_bhp.sv
test/tb_deflate_bhp.sv

//--- Makefile
TOP = tb_deflate_bhp
LOG = sim.log

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "^Simulation completed successfully$$" $(LOG) || (echo "Run did not pass"; exit 1)

obj_dir/V$(TOP): deflate_bhp.f design/*.sv test/*.sv
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f deflate_bhp.f

lint:
	verilator --lint-only -Wall --timing --top-module deflate_bhp \
		$(shell grep '^design/' deflate_bhp.f)

clean:
	rm -rf obj_dir $(LOG)
